//--- bench/pktctrl_model.svh
/*
 * Memory model of the capture controller with the expected register and stream
 * read values. Included inside the testbench module.
 */
`ifndef PKTCTRL_MODEL_SVH
`define PKTCTRL_MODEL_SVH

// Stored samples by address, then bank
logic [SAMPLE_W-1:0] model_mem [DEPTH][NUM_BANKS];

function automatic void model_store(input int addr, input int bank,
                                    input logic [SAMPLE_W-1:0] sample);
    model_mem[addr][bank] = sample;
endfunction

// Slice 0 holds the lowest bits
function automatic logic [SLICE_W-1:0] expected_slice(input int bank, input int slice,
                                                      input int addr);
    logic [SAMPLE_W-1:0] sample;
    sample = model_mem[addr][bank];
    return sample[slice*SLICE_W +: SLICE_W];
endfunction

// --------------------
// Stream order
// --------------------
// Address first, then bank, low half before high half
function automatic logic [HALF_W-1:0] expected_half(input int idx);
    logic [SAMPLE_W-1:0] sample;
    sample = model_mem[idx / (2 * NUM_BANKS)][(idx / 2) % NUM_BANKS];
    if (idx % 2 == 1) begin
        return sample[SAMPLE_W-1:HALF_W];
    end
    return sample[HALF_W-1:0];
endfunction

`endif

//--- bench/pktctrl_tb.sv
/*
 * Testbench of the packet capture controller. Random captures from an LFSR,
 * register and stream reads checked against the memory model.
 */
`timescale 1ns/1ps
module pktctrl_tb import pktctrl_pkg::*; ();

    localparam int NUM_BANKS  = 4;
    localparam int ADDR_W     = 6;
    localparam int DEPTH      = 2 ** ADDR_W;
    localparam int BANK_W     = sel_width(NUM_BANKS);
    localparam int STREAM_LEN = DEPTH * NUM_BANKS * 2;
    localparam int NUM_READS  = 20;
    localparam int CLK_EDGES  = 8;
    localparam int PART_LEN   = 12;
    localparam logic [31:0] SEED = 32'h51de_decb;

    logic                               pktctrl_clk;
    logic                               pktctrl_rstn;
    logic                               rf_capture_mode;
    logic                               rf_capture_start;
    logic [GAP_W-1:0]                   rf_pktctrl_gap;
    logic [GAP_W-1:0]                   rf_pktctrl_phase;
    logic [NUM_BANKS-1:0][SAMPLE_W-1:0] adc_data;
    logic [BANK_W-1:0]                  rf_mdio_bank_sel;
    logic [SLICE_SEL_W-1:0]             rf_mdio_slice_sel;
    logic [ADDR_W-1:0]                  rf_mdio_memory_addr;
    logic [SLICE_W-1:0]                 rf_mdio_pkt_data;
    logic                               clk_rd;
    logic [HALF_W-1:0]                  adc_stream_data;
    logic                               adc_stream_valid;

    logic [31:0]    lfsr_q;
    int             hg;
    int             test_errors;
    int             total_errors;
    int             tests_run;
    int             tests_failed;
    int             checks;
    capture_state_e read_path;

    `include "pktctrl_model.svh"

    pktctrl_top #(.NUM_BANKS(NUM_BANKS), .ADDR_W(ADDR_W)) pktctrl_top_i (
        .pktctrl_clk         (pktctrl_clk),
        .pktctrl_rstn        (pktctrl_rstn),
        .rf_capture_mode     (rf_capture_mode),
        .rf_capture_start    (rf_capture_start),
        .rf_pktctrl_gap      (rf_pktctrl_gap),
        .rf_pktctrl_phase    (rf_pktctrl_phase),
        .adc_data            (adc_data),
        .rf_mdio_bank_sel    (rf_mdio_bank_sel),
        .rf_mdio_slice_sel   (rf_mdio_slice_sel),
        .rf_mdio_memory_addr (rf_mdio_memory_addr),
        .rf_mdio_pkt_data    (rf_mdio_pkt_data),
        .clk_rd              (clk_rd),
        .adc_stream_data     (adc_stream_data),
        .adc_stream_valid    (adc_stream_valid)
    );

    initial begin
        pktctrl_clk = 1'b0;
        forever #5 pktctrl_clk = ~pktctrl_clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[62:0], fb};
        end
        return v;
    endfunction

    // --------------------
    // Checks and reporting
    // --------------------
    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            $display("FAILED at %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("FAILED at %0d ns: %s", $time, what);
            test_errors++;
        end
    endtask

    task automatic finish_test(input int num, input string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %0d %s (%s): ok", num, name, read_path.name());
        end else begin
            tests_failed++;
            $display("test %0d %s (%s): %0d errors", num, name, read_path.name(), test_errors);
        end
        test_errors = 0;
    endtask

    // --------------------
    // Stimulus
    // --------------------
    task automatic run_capture(input logic mode);
        read_path        = mode ? REG_READ : STREAM_READ;
        rf_capture_mode  = mode;
        rf_capture_start = 1'b1;
        @(posedge pktctrl_clk);
        @(negedge pktctrl_clk);
        rf_capture_start = 1'b0;
        // Second edge after the start edge stores address 0
        for (int k = 0; k < DEPTH; k++) begin
            @(negedge pktctrl_clk);
            for (int b = 0; b < NUM_BANKS; b++) begin
                adc_data[b] = SAMPLE_W'(rand_bits(SAMPLE_W));
                model_store(k, b, adc_data[b]);
            end
        end
        repeat (2) @(negedge pktctrl_clk);
    endtask

    task automatic read_registers();
        int bank;
        int slice;
        int addr;
        for (int i = 0; i < NUM_READS; i++) begin
            bank                = rand_bits(BANK_W) % NUM_BANKS;
            slice               = rand_bits(SLICE_SEL_W);
            addr                = rand_bits(ADDR_W);
            rf_mdio_bank_sel    = BANK_W'(bank);
            rf_mdio_slice_sel   = SLICE_SEL_W'(slice);
            rf_mdio_memory_addr = ADDR_W'(addr);
            repeat (3) @(posedge pktctrl_clk);
            @(negedge pktctrl_clk);
            check_eq(rf_mdio_pkt_data, expected_slice(bank, slice, addr),
                     $sformatf("slice %0d of bank %0d at address %0d", slice, bank, addr));
        end
    endtask

    task automatic collect_stream(input int first, input int count);
        int wait_cnt;
        int limit;
        limit = 4 * hg + 16;
        for (int idx = first; idx < first + count; idx++) begin
            wait_cnt = 0;
            do begin
                @(negedge pktctrl_clk);
                wait_cnt++;
            end while (!adc_stream_valid && wait_cnt < limit);
            check_true(adc_stream_valid,
                       $sformatf("no stream valid within %0d cycles for half %0d", limit, idx));
            if (!adc_stream_valid) begin
                return;
            end
            check_eq(adc_stream_data, expected_half(idx), $sformatf("stream half %0d", idx));
            if (idx > first) begin
                check_eq(wait_cnt, hg, $sformatf("strobe spacing before half %0d", idx));
            end
        end
    endtask

    task automatic check_clk_rd_spacing();
        int  cnt;
        logic prev;
        prev = clk_rd;
        for (int n = 0; n < CLK_EDGES; n++) begin
            cnt = 0;
            do begin
                @(negedge pktctrl_clk);
                cnt++;
            end while (clk_rd == prev && cnt < 2 * hg + 4);
            check_eq(cnt, hg, $sformatf("cycles between clk_rd edges, edge %0d", n));
            prev = clk_rd;
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        int cnt;
        lfsr_q              = SEED;
        read_path           = IDLE;
        pktctrl_rstn        = 1'b0;
        rf_capture_mode     = 1'b0;
        rf_capture_start    = 1'b0;
        adc_data            = '0;
        rf_mdio_bank_sel    = '0;
        rf_mdio_slice_sel   = '0;
        rf_mdio_memory_addr = '0;
        rf_pktctrl_gap      = GAP_W'(4 + rand_bits(6) % 37);
        hg                  = rf_pktctrl_gap / 2;
        rf_pktctrl_phase    = GAP_W'(rand_bits(5) % hg);

        repeat (8) begin
            @(negedge pktctrl_clk);
            check_true(!clk_rd && !adc_stream_valid, "clk_rd or adc_stream_valid high in reset");
        end
        pktctrl_rstn = 1'b1;
        cnt = 0;
        do begin
            @(negedge pktctrl_clk);
            cnt++;
            check_true(!adc_stream_valid, "adc_stream_valid high with no stream running");
        end while (!clk_rd && cnt < hg + 4);
        check_eq(cnt, rf_pktctrl_phase + 1, "cycles to the first clk_rd edge");
        finish_test(1, "reset and first clk_rd edge");

        check_clk_rd_spacing();
        finish_test(2, "read clock spacing");

        run_capture(1'b1);
        read_registers();
        finish_test(3, "register read");

        run_capture(1'b0);
        collect_stream(0, STREAM_LEN);
        repeat (2 * hg + 2) begin
            @(negedge pktctrl_clk);
            check_true(!adc_stream_valid, "stream went on after its last half");
        end
        finish_test(4, "full stream with strobe spacing");

        run_capture(1'b0);
        collect_stream(0, PART_LEN);
        rf_capture_mode = 1'b1;
        repeat (6) begin
            @(negedge pktctrl_clk);
            check_true(!adc_stream_valid, "stream valid while in register read");
        end
        rf_capture_mode = 1'b0;
        collect_stream(0, PART_LEN);
        finish_test(5, "stream restart after register read");

        rf_capture_mode = 1'b1;
        repeat (2) @(negedge pktctrl_clk);
        run_capture(1'b1);
        read_registers();
        finish_test(6, "new capture from register read");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, total_errors);
        if (total_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog sized from the captures, the reads and every stream half at the strobe rate
    initial begin
        int budget;
        @(posedge pktctrl_rstn);
        budget = 2 * (8 + 4 * (DEPTH + 4) + 2 * NUM_READS * 4 + 64
                 + (STREAM_LEN + 2 * PART_LEN + CLK_EDGES + 16) * hg);
        repeat (budget) @(posedge pktctrl_clk);
        $display("Watchdog: run did not finish within %0d cycles", budget);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- design/capture_fsm.sv
/*
 * Capture and readout FSM. Sequences one capture pass, then register read or
 * stream read as chosen by rf_capture_mode.
 */
`timescale 1ns/1ps
module capture_fsm import pktctrl_pkg::*; (
    input  logic        pktctrl_clk,
    input  logic        pktctrl_rstn,
    input  logic        rf_capture_mode,
    input  logic        rf_capture_start,
    pkt_ctrl_if.fsm_mp  ctrl
);

    capture_state_e state_q;
    capture_state_e state_d;

    always_ff @(posedge pktctrl_clk or negedge pktctrl_rstn) begin
        if (!pktctrl_rstn) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------
    // Next state and enables
    // --------------------
    always_comb begin
        state_d             = state_q;
        ctrl.write_en       = 1'b0;
        ctrl.reg_read_en    = 1'b0;
        ctrl.stream_read_en = 1'b0;
        case (state_q)
            IDLE: begin
                if (rf_capture_start) begin
                    state_d = WRITE;
                end
            end
            WRITE: begin
                // Stays high on the last address so that it is written too
                ctrl.write_en = 1'b1;
                if (ctrl.wr_done) begin
                    state_d = WRITE_DONE;
                end
            end
            WRITE_DONE: begin
                state_d = rf_capture_mode ? REG_READ : STREAM_READ;
            end
            REG_READ: begin
                ctrl.reg_read_en = 1'b1;
                if (rf_capture_start) begin
                    state_d          = WRITE;
                    ctrl.reg_read_en = 1'b0;
                end else if (!rf_capture_mode) begin
                    state_d          = STREAM_READ;
                    ctrl.reg_read_en = 1'b0;
                end
            end
            STREAM_READ: begin
                ctrl.stream_read_en = 1'b1;
                if (rf_capture_mode) begin
                    state_d             = REG_READ;
                    ctrl.stream_read_en = 1'b0;
                end else if (ctrl.stream_done) begin
                    // Enable held so the last half still goes out
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

endmodule

//--- design/capture_writer.sv
/*
 * Write address counter for one capture pass over the sample memory.
 * Flags the last address so the FSM can close the pass.
 */
`timescale 1ns/1ps
module capture_writer #(
    parameter int ADDR_W = 6
) (
    input  logic               pktctrl_clk,
    input  logic               pktctrl_rstn,
    pkt_ctrl_if.writer_mp      ctrl,
    output logic [ADDR_W-1:0]  wr_addr
);

    // --------------------
    // Address counter
    // --------------------
    always_ff @(posedge pktctrl_clk or negedge pktctrl_rstn) begin
        if (!pktctrl_rstn) begin
            wr_addr <= '0;
        end else if (!ctrl.write_en) begin
            wr_addr <= '0;
        end else begin
            // Wraps to zero after the last address
            wr_addr <= wr_addr + 1'b1;
        end
    end

    // Last address of the pass
    assign ctrl.wr_done = &wr_addr;

endmodule

//--- design/pkt_ctrl_if.sv
/*
 * Enables and done flags between the capture FSM and the datapath blocks.
 * At most one enable is high in any cycle.
 */
`timescale 1ns/1ps
interface pkt_ctrl_if;

    logic write_en;
    logic reg_read_en;
    logic stream_read_en;
    logic wr_done;
    logic stream_done;

    modport fsm_mp (
        output write_en,
        output reg_read_en,
        output stream_read_en,
        input  wr_done,
        input  stream_done
    );

    modport writer_mp (input write_en, output wr_done);

    modport bank_mp (input write_en, input reg_read_en, input stream_read_en);

    modport stream_mp (input stream_read_en, output stream_done);

endinterface

//--- design/pktctrl_pkg.sv
/*
 * Shared widths, controller states and helper functions of the packet capture
 * controller. Modules take it by wildcard import in their header.
 */
package pktctrl_pkg;

    // --------------------
    // Sample and stream widths
    // --------------------
    localparam int SAMPLE_W          = 36;
    localparam int HALF_W            = SAMPLE_W / 2;
    localparam int SLICE_W           = 9;
    localparam int SLICES_PER_SAMPLE = SAMPLE_W / SLICE_W;
    localparam int SLICE_SEL_W       = $clog2(SLICES_PER_SAMPLE);

    // Read clock gap and phase settings
    localparam int GAP_W = 9;

    // --------------------
    // Controller states
    // --------------------
    typedef enum logic [2:0] {
        IDLE,
        WRITE,
        WRITE_DONE,
        REG_READ,
        STREAM_READ
    } capture_state_e;

    // Select width for n items, at least one bit
    function automatic int sel_width(input int n);
        int w;
        w = (n > 1) ? $clog2(n) : 1;
        return w;
    endfunction

endpackage

//--- design/pktctrl_top.sv
/*
 * Packet capture controller top level. Captures NUM_BANKS ADC channels into
 * memory and reads them back by register selection or as a paced stream.
 */
`timescale 1ns/1ps
module pktctrl_top import pktctrl_pkg::*; #(
    parameter int NUM_BANKS = 4,
    parameter int ADDR_W    = 6
) (
    input  logic                                pktctrl_clk,
    input  logic                                pktctrl_rstn,
    input  logic                                rf_capture_mode,
    input  logic                                rf_capture_start,
    input  logic [GAP_W-1:0]                    rf_pktctrl_gap,
    input  logic [GAP_W-1:0]                    rf_pktctrl_phase,
    input  logic [NUM_BANKS-1:0][SAMPLE_W-1:0]  adc_data,
    input  logic [sel_width(NUM_BANKS)-1:0]     rf_mdio_bank_sel,
    input  logic [SLICE_SEL_W-1:0]              rf_mdio_slice_sel,
    input  logic [ADDR_W-1:0]                   rf_mdio_memory_addr,
    output logic [SLICE_W-1:0]                  rf_mdio_pkt_data,
    output logic                                clk_rd,
    output logic [HALF_W-1:0]                   adc_stream_data,
    output logic                                adc_stream_valid
);

    logic [ADDR_W-1:0]                  wr_addr;
    logic [ADDR_W-1:0]                  stream_addr;
    logic [NUM_BANKS-1:0][SAMPLE_W-1:0] rd_word;
    logic                               data_rd_en;

    pkt_ctrl_if ctrl_if ();

    capture_fsm capture_fsm_i (
        .pktctrl_clk      (pktctrl_clk),
        .pktctrl_rstn     (pktctrl_rstn),
        .rf_capture_mode  (rf_capture_mode),
        .rf_capture_start (rf_capture_start),
        .ctrl             (ctrl_if.fsm_mp)
    );

    read_strobe_timer read_strobe_timer_i (
        .pktctrl_clk      (pktctrl_clk),
        .pktctrl_rstn     (pktctrl_rstn),
        .rf_pktctrl_gap   (rf_pktctrl_gap),
        .rf_pktctrl_phase (rf_pktctrl_phase),
        .clk_rd           (clk_rd),
        .data_rd_en       (data_rd_en)
    );

    capture_writer #(.ADDR_W(ADDR_W)) capture_writer_i (
        .pktctrl_clk  (pktctrl_clk),
        .pktctrl_rstn (pktctrl_rstn),
        .ctrl         (ctrl_if.writer_mp),
        .wr_addr      (wr_addr)
    );

    sample_bank_array #(.NUM_BANKS(NUM_BANKS), .ADDR_W(ADDR_W)) sample_bank_array_i (
        .pktctrl_clk         (pktctrl_clk),
        .pktctrl_rstn        (pktctrl_rstn),
        .ctrl                (ctrl_if.bank_mp),
        .adc_data            (adc_data),
        .wr_addr             (wr_addr),
        .stream_addr         (stream_addr),
        .rf_mdio_memory_addr (rf_mdio_memory_addr),
        .rf_mdio_bank_sel    (rf_mdio_bank_sel),
        .rf_mdio_slice_sel   (rf_mdio_slice_sel),
        .rd_word             (rd_word),
        .rf_mdio_pkt_data    (rf_mdio_pkt_data)
    );

    stream_reader #(.NUM_BANKS(NUM_BANKS), .ADDR_W(ADDR_W)) stream_reader_i (
        .pktctrl_clk      (pktctrl_clk),
        .pktctrl_rstn     (pktctrl_rstn),
        .ctrl             (ctrl_if.stream_mp),
        .data_rd_en       (data_rd_en),
        .rd_word          (rd_word),
        .stream_addr      (stream_addr),
        .adc_stream_data  (adc_stream_data),
        .adc_stream_valid (adc_stream_valid)
    );

endmodule

//--- design/read_strobe_timer.sv
/*
 * Read clock timer. A half-gap counter toggles clk_rd at the phase match and
 * pulses data_rd_en once per counter period.
 */
`timescale 1ns/1ps
module read_strobe_timer import pktctrl_pkg::*; (
    input  logic             pktctrl_clk,
    input  logic             pktctrl_rstn,
    input  logic [GAP_W-1:0] rf_pktctrl_gap,
    input  logic [GAP_W-1:0] rf_pktctrl_phase,
    output logic             clk_rd,
    output logic             data_rd_en
);

    logic [GAP_W-1:0] cnt_q;
    logic [GAP_W-1:0] cnt_last;

    // Half the gap minus one, gap of 4 or more
    assign cnt_last = (rf_pktctrl_gap >> 1) - 1'b1;

    always_ff @(posedge pktctrl_clk or negedge pktctrl_rstn) begin
        if (!pktctrl_rstn) begin
            cnt_q <= '0;
        end else if (cnt_q >= cnt_last) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge pktctrl_clk or negedge pktctrl_rstn) begin
        if (!pktctrl_rstn) begin
            clk_rd     <= 1'b0;
            data_rd_en <= 1'b0;
        end else begin
            if (cnt_q == rf_pktctrl_phase) begin
                clk_rd <= ~clk_rd;
            end
            data_rd_en <= (cnt_q == cnt_last);
        end
    end

endmodule

//--- design/sample_bank_array.sv
/*
 * Sample storage with one memory per ADC channel, the shared access address
 * mux, and the register-read slice selection.
 */
`timescale 1ns/1ps
module sample_bank_array import pktctrl_pkg::*; #(
    parameter int NUM_BANKS = 4,
    parameter int ADDR_W    = 6
) (
    input  logic                                pktctrl_clk,
    input  logic                                pktctrl_rstn,
    pkt_ctrl_if.bank_mp                         ctrl,
    input  logic [NUM_BANKS-1:0][SAMPLE_W-1:0]  adc_data,
    input  logic [ADDR_W-1:0]                   wr_addr,
    input  logic [ADDR_W-1:0]                   stream_addr,
    input  logic [ADDR_W-1:0]                   rf_mdio_memory_addr,
    input  logic [sel_width(NUM_BANKS)-1:0]     rf_mdio_bank_sel,
    input  logic [SLICE_SEL_W-1:0]              rf_mdio_slice_sel,
    output logic [NUM_BANKS-1:0][SAMPLE_W-1:0]  rd_word,
    output logic [SLICE_W-1:0]                  rf_mdio_pkt_data
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [ADDR_W-1:0] mem_addr;
    logic              mem_we;
    logic [1:0]        reg_rd_q;
    logic [SLICE_W-1:0] slice_sel_data;

    // --------------------
    // Access address mux
    // --------------------
    always_ff @(posedge pktctrl_clk or negedge pktctrl_rstn) begin
        if (!pktctrl_rstn) begin
            mem_addr <= '0;
            mem_we   <= 1'b0;
            reg_rd_q <= '0;
        end else begin
            mem_we   <= ctrl.write_en;
            reg_rd_q <= {reg_rd_q[0], ctrl.reg_read_en};
            if (ctrl.write_en) begin
                mem_addr <= wr_addr;
            end else if (ctrl.reg_read_en) begin
                mem_addr <= rf_mdio_memory_addr;
            end else if (ctrl.stream_read_en) begin
                mem_addr <= stream_addr;
            end else begin
                mem_addr <= '0;
            end
        end
    end

    // --------------------
    // Sample memories
    // --------------------
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        logic [SAMPLE_W-1:0] mem [DEPTH];
        logic [SAMPLE_W-1:0] dout_q;

        // All banks share address and strobe, synchronous read
        always_ff @(posedge pktctrl_clk) begin
            if (mem_we) begin
                mem[mem_addr] <= adc_data[b];
            end
            dout_q <= mem[mem_addr];
        end

        assign rd_word[b] = dout_q;
    end

    // --------------------
    // Register read slice
    // --------------------
    // Slice 0 is the lowest bits of the sample
    assign slice_sel_data = rd_word[rf_mdio_bank_sel][rf_mdio_slice_sel * SLICE_W +: SLICE_W];

    // Only updated while read data of a register read is on rd_word
    always_ff @(posedge pktctrl_clk) begin
        if (reg_rd_q[1]) begin
            rf_mdio_pkt_data <= slice_sel_data;
        end
    end

endmodule

//--- design/stream_reader.sv
/*
 * Stream read pointer. Walks address, bank and half in order and sends one
 * 18-bit half-sample with a valid flag on each read strobe.
 */
`timescale 1ns/1ps
module stream_reader import pktctrl_pkg::*; #(
    parameter int NUM_BANKS = 4,
    parameter int ADDR_W    = 6
) (
    input  logic                                pktctrl_clk,
    input  logic                                pktctrl_rstn,
    pkt_ctrl_if.stream_mp                       ctrl,
    input  logic                                data_rd_en,
    input  logic [NUM_BANKS-1:0][SAMPLE_W-1:0]  rd_word,
    output logic [ADDR_W-1:0]                   stream_addr,
    output logic [HALF_W-1:0]                   adc_stream_data,
    output logic                                adc_stream_valid
);

    localparam int BANK_W = sel_width(NUM_BANKS);
    localparam logic [BANK_W-1:0] BANK_LAST = BANK_W'(NUM_BANKS - 1);

    logic              half_q;
    logic [BANK_W-1:0] bank_q;
    logic [ADDR_W-1:0] addr_q;
    logic [BANK_W-1:0] bank_d;
    logic [ADDR_W-1:0] addr_d;
    logic [1:0]        settle_q;
    logic              emit;

    // No strobe taken until the first word has come through the memory
    assign emit = ctrl.stream_read_en && data_rd_en && settle_q[1];

    // Next pointer after the current half
    always_comb begin
        bank_d = bank_q;
        addr_d = addr_q;
        if (half_q) begin
            if (bank_q == BANK_LAST) begin
                bank_d = '0;
                addr_d = addr_q + 1'b1;
            end else begin
                bank_d = bank_q + 1'b1;
            end
        end
    end

    // Next address goes out on the strobe itself, so rd_word turns over in time
    assign stream_addr = emit ? addr_d : addr_q;

    assign ctrl.stream_done = emit && half_q && (bank_q == BANK_LAST) && (&addr_q);

    always_ff @(posedge pktctrl_clk or negedge pktctrl_rstn) begin
        if (!pktctrl_rstn) begin
            half_q           <= 1'b0;
            bank_q           <= '0;
            addr_q           <= '0;
            settle_q         <= '0;
            adc_stream_valid <= 1'b0;
        end else if (!ctrl.stream_read_en) begin
            half_q           <= 1'b0;
            bank_q           <= '0;
            addr_q           <= '0;
            settle_q         <= '0;
            adc_stream_valid <= 1'b0;
        end else begin
            if (!settle_q[1]) begin
                settle_q <= settle_q + 1'b1;
            end
            adc_stream_valid <= emit;
            if (emit) begin
                half_q <= ~half_q;
                bank_q <= bank_d;
                addr_q <= addr_d;
            end
        end
    end

    always_ff @(posedge pktctrl_clk) begin
        if (emit) begin
            adc_stream_data <= half_q ? rd_word[bank_q][SAMPLE_W-1:HALF_W]
                                      : rd_word[bank_q][HALF_W-1:0];
        end
    end

endmodule

//--- files.f
+incdir+bench
design/pktctrl_pkg.sv
design/pkt_ctrl_if.sv
design/capture_fsm.sv
design/read_strobe_timer.sv
design/capture_writer.sv
design/sample_bank_array.sv
design/stream_reader.sv
design/pktctrl_top.sv
bench/pktctrl_tb.sv
